// File: source/capture_pkg.sv
package capture_pkg;

    // ********************
    // widths and defaults
    // ********************

    localparam int cam_count      = 2;
    localparam int pixel_width    = 16;
    localparam int byte_width     = 8;
    localparam int count_width    = 24;  // shared by pixel, line and frame counters
    localparam int reg_addr_width = 4;
    localparam int reg_data_width = 32;
    localparam int tick_div_reset = 30;  // one tick every thirty frames out of reset

    // ********************
    // packer states
    // ********************

    typedef enum logic [1:0] {
        pk_idle = 2'd0,  // href low, no line in progress
        pk_high = 2'd1,  // inside a line, next byte is the high half
        pk_low  = 2'd2   // high half held, next byte completes the pixel
    } packer_state_e;

    // ********************
    // host register map
    // ********************

    typedef enum logic [reg_addr_width-1:0] {
        reg_ctrl      = 4'd0,   // bit n enables camera n
        reg_tick_div0 = 4'd1,
        reg_tick_div1 = 4'd2,
        reg_pixels0   = 4'd4,
        reg_lines0    = 4'd5,
        reg_csum0     = 4'd6,
        reg_frames0   = 4'd7,
        reg_pixels1   = 4'd8,
        reg_lines1    = 4'd9,
        reg_csum1     = 4'd10,
        reg_frames1   = 4'd11
    } reg_addr_e;

endpackage

// File: source/pixel_bus_if.sv
interface pixel_bus_if;
    import capture_pkg::*;

    logic                   pix_valid;  // one cycle per completed pixel
    logic [pixel_width-1:0] pix_data;
    logic                   line_end;   // href has just fallen
    logic                   frame_end;  // vsync has just risen

    modport src (
        output pix_valid,
        output pix_data,
        output line_end,
        output frame_end
    );

    modport dst (
        input  pix_valid,
        input  pix_data,
        input  line_end,
        input  frame_end
    );

endinterface

// File: source/frame_stats_if.sv
interface frame_stats_if;
    import capture_pkg::*;

    logic [count_width-1:0] pixels;    // pixels in the last complete frame
    logic [count_width-1:0] lines;
    logic [pixel_width-1:0] checksum;  // xor over every pixel of that frame
    logic [count_width-1:0] frames;    // frames seen since reset

    modport src (
        output pixels,
        output lines,
        output checksum,
        output frames
    );

    modport dst (
        input  pixels,
        input  lines,
        input  checksum,
        input  frames
    );

endinterface

// File: source/rgb565_packer.sv
module rgb565_packer (
    input  logic                               clk   ,
    input  logic                               rst_n ,
    input  logic                               enable,
    input  logic                               vsync ,
    input  logic                               href  ,
    input  logic [capture_pkg::byte_width-1:0] data  ,
    pixel_bus_if.src                           bus
);
    import capture_pkg::*;

    packer_state_e         state;
    logic [byte_width-1:0] high_byte;
    logic                  href_q;
    logic                  vsync_q;

    // ********************
    // byte pairing FSM
    // ********************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= pk_idle;
        end else if (!enable || !href) begin
            state <= pk_idle;  // a dangling high byte is simply forgotten here
        end else begin
            case (state)
                pk_idle : state <= pk_low;
                pk_high : state <= pk_low;
                pk_low  : state <= pk_high;
                default : state <= pk_idle;
            endcase
        end
    end

    // the pixel strobe lines up with the cycle after the low byte
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.pix_valid <= 1'b0;
        end else begin
            bus.pix_valid <= enable && href && (state == pk_low);
        end
    end

    always_ff @(posedge clk) begin
        if (href && state != pk_low) begin
            high_byte <= data;  // first byte of the pair carries red and upper green
        end
        if (href && state == pk_low) begin
            bus.pix_data <= {high_byte, data};
        end
    end

    // ********************
    // line and frame edges
    // ********************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            href_q         <= 1'b0;
            vsync_q        <= 1'b0;
            bus.line_end   <= 1'b0;
            bus.frame_end  <= 1'b0;
        end else begin
            href_q         <= href;
            vsync_q        <= vsync;
            bus.line_end   <= enable && href_q && !href;   // falling href
            bus.frame_end  <= enable && vsync && !vsync_q; // rising vsync
        end
    end

    // a camera never raises vsync in the middle of active pixels
    pixel_and_frame_apart: assert property (
        @(posedge clk) disable iff (!rst_n) !(bus.pix_valid && bus.frame_end)
    ) else $error("pixel strobe collided with frame end");

endmodule

// File: source/frame_monitor.sv
module frame_monitor (
    input  logic                                clk     ,
    input  logic                                rst_n   ,
    input  logic [capture_pkg::count_width-1:0] tick_div,
    pixel_bus_if.dst                            bus     ,
    frame_stats_if.src                          stats   ,
    output logic                                cam_tick
);
    import capture_pkg::*;

    logic [count_width-1:0] pix_cnt;
    logic [count_width-1:0] line_cnt;
    logic [pixel_width-1:0] csum;
    logic [count_width-1:0] pix_next;
    logic [count_width-1:0] line_next;
    logic [pixel_width-1:0] csum_next;
    logic [count_width-1:0] tick_cnt;
    logic [count_width-1:0] tick_div_q;
    logic [count_width-1:0] tick_limit;

    // running totals including whatever arrives on this very edge
    always_comb begin
        pix_next   = bus.pix_valid ? pix_cnt + 1'b1 : pix_cnt;
        line_next  = bus.line_end ? line_cnt + 1'b1 : line_cnt;
        csum_next  = bus.pix_valid ? csum ^ bus.pix_data : csum;
        tick_limit = (tick_div == '0) ? count_width'(1) : tick_div;  // zero acts as one
    end

    // ********************
    // per-frame statistics
    // ********************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_cnt        <= '0;
            line_cnt       <= '0;
            csum           <= '0;
            stats.pixels   <= '0;
            stats.lines    <= '0;
            stats.checksum <= '0;
            stats.frames   <= '0;
        end else if (bus.frame_end) begin
            stats.pixels   <= pix_next;
            stats.lines    <= line_next;
            stats.checksum <= csum_next;
            stats.frames   <= stats.frames + 1'b1;
            pix_cnt        <= '0;
            line_cnt       <= '0;
            csum           <= '0;
        end else begin
            pix_cnt        <= pix_next;
            line_cnt       <= line_next;
            csum           <= csum_next;
        end
    end

    // ********************
    // frame tick divider
    // ********************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt   <= '0;
            tick_div_q <= count_width'(tick_div_reset);
            cam_tick   <= 1'b0;
        end else begin
            tick_div_q <= tick_div;
            cam_tick   <= 1'b0;
            if (bus.frame_end) begin
                if (tick_cnt >= tick_limit - 1'b1) begin
                    tick_cnt <= '0;
                    cam_tick <= 1'b1;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end else if (tick_div != tick_div_q) begin
                tick_cnt <= '0;  // a new divisor starts counting from the next frame
            end
        end
    end

    // frame_end is a single cycle strobe, so the tick is a single pulse too
    tick_is_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) cam_tick |=> !cam_tick
    ) else $error("cam_tick held for more than one cycle");

endmodule

// File: source/capture_regs.sv
module capture_regs (
    input  logic                                   clk       ,
    input  logic                                   rst_n     ,
    input  logic                                   wr_en     ,
    input  logic                                   rd_en     ,
    input  logic [capture_pkg::reg_addr_width-1:0] addr      ,
    input  logic [capture_pkg::reg_data_width-1:0] wr_data   ,
    output logic [capture_pkg::reg_data_width-1:0] rd_data   ,
    output logic                                   rd_valid  ,
    output logic [capture_pkg::cam_count-1:0]      cam_enable,
    output logic [capture_pkg::count_width-1:0]    tick_div0 ,
    output logic [capture_pkg::count_width-1:0]    tick_div1 ,
    frame_stats_if.dst                             stats0    ,
    frame_stats_if.dst                             stats1
);
    import capture_pkg::*;

    logic [reg_data_width-1:0] rd_mux;

    // ********************
    // control registers
    // ********************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cam_enable <= '1;  // both cameras run out of reset
            tick_div0  <= count_width'(tick_div_reset);
            tick_div1  <= count_width'(tick_div_reset);
        end else if (wr_en) begin
            case (addr)
                reg_ctrl      : cam_enable <= wr_data[cam_count-1:0];
                reg_tick_div0 : tick_div0  <= wr_data[count_width-1:0];
                reg_tick_div1 : tick_div1  <= wr_data[count_width-1:0];
                default       : ;  // statistics are read only
            endcase
        end
    end

    // ********************
    // read path
    // ********************

    always_comb begin
        case (addr)
            reg_ctrl      : rd_mux = reg_data_width'(cam_enable);
            reg_tick_div0 : rd_mux = reg_data_width'(tick_div0);
            reg_tick_div1 : rd_mux = reg_data_width'(tick_div1);
            reg_pixels0   : rd_mux = reg_data_width'(stats0.pixels);
            reg_lines0    : rd_mux = reg_data_width'(stats0.lines);
            reg_csum0     : rd_mux = reg_data_width'(stats0.checksum);
            reg_frames0   : rd_mux = reg_data_width'(stats0.frames);
            reg_pixels1   : rd_mux = reg_data_width'(stats1.pixels);
            reg_lines1    : rd_mux = reg_data_width'(stats1.lines);
            reg_csum1     : rd_mux = reg_data_width'(stats1.checksum);
            reg_frames1   : rd_mux = reg_data_width'(stats1.frames);
            default       : rd_mux = '0;  // holes in the map read as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_mux;  // sampled with the strobe so the host sees a stable word
        end
    end

    // a camera's statistics only move when its frame count steps by one
    stats0_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed({stats0.pixels, stats0.lines, stats0.checksum, stats0.frames})
            |-> stats0.frames == $past(stats0.frames) + 1'b1
    ) else $error("camera 0 statistics changed without a new frame");

    stats1_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed({stats1.pixels, stats1.lines, stats1.checksum, stats1.frames})
            |-> stats1.frames == $past(stats1.frames) + 1'b1
    ) else $error("camera 1 statistics changed without a new frame");

endmodule

// File: source/capture_top.sv
module capture_top (
    input  logic                                   clk       ,
    input  logic                                   rst_n     ,

    input  logic                                   cam0_vsync,
    input  logic                                   cam0_href ,
    input  logic [capture_pkg::byte_width-1:0]     cam0_data ,

    input  logic                                   cam1_vsync,
    input  logic                                   cam1_href ,
    input  logic [capture_pkg::byte_width-1:0]     cam1_data ,

    input  logic                                   wr_en     ,
    input  logic                                   rd_en     ,
    input  logic [capture_pkg::reg_addr_width-1:0] addr      ,
    input  logic [capture_pkg::reg_data_width-1:0] wr_data   ,
    output logic [capture_pkg::reg_data_width-1:0] rd_data   ,
    output logic                                   rd_valid  ,

    output logic                                   cam0_tick ,
    output logic                                   cam1_tick
);
    import capture_pkg::*;

    logic [cam_count-1:0]   cam_enable;
    logic [count_width-1:0] tick_div0;
    logic [count_width-1:0] tick_div1;

    pixel_bus_if   pix_bus0 ();
    pixel_bus_if   pix_bus1 ();
    frame_stats_if stats0   ();
    frame_stats_if stats1   ();

    // ********************
    // camera channels
    // ********************

    rgb565_packer u_cam0_packer (
        .clk     (clk          ),
        .rst_n   (rst_n        ),
        .enable  (cam_enable[0]),
        .vsync   (cam0_vsync   ),
        .href    (cam0_href    ),
        .data    (cam0_data    ),
        .bus     (pix_bus0     )
    );

    frame_monitor u_cam0_monitor (
        .clk     (clk          ),
        .rst_n   (rst_n        ),
        .tick_div(tick_div0    ),
        .bus     (pix_bus0     ),
        .stats   (stats0       ),
        .cam_tick(cam0_tick    )
    );

    rgb565_packer u_cam1_packer (
        .clk     (clk          ),
        .rst_n   (rst_n        ),
        .enable  (cam_enable[1]),
        .vsync   (cam1_vsync   ),
        .href    (cam1_href    ),
        .data    (cam1_data    ),
        .bus     (pix_bus1     )
    );

    frame_monitor u_cam1_monitor (
        .clk     (clk          ),
        .rst_n   (rst_n        ),
        .tick_div(tick_div1    ),
        .bus     (pix_bus1     ),
        .stats   (stats1       ),
        .cam_tick(cam1_tick    )
    );

    // ********************
    // host registers
    // ********************

    capture_regs u_regs (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .wr_en     (wr_en     ),
        .rd_en     (rd_en     ),
        .addr      (addr      ),
        .wr_data   (wr_data   ),
        .rd_data   (rd_data   ),
        .rd_valid  (rd_valid  ),
        .cam_enable(cam_enable),
        .tick_div0 (tick_div0 ),
        .tick_div1 (tick_div1 ),
        .stats0    (stats0    ),
        .stats1    (stats1    )
    );

endmodule

// File: tests/tb_capture_top.sv
module tb_capture_top;
    import capture_pkg::*;

    localparam int max_cycles = 512;
    localparam int wait_limit = 20;

    logic                      clk;
    logic                      rst_n;
    logic                      cam0_vsync;
    logic                      cam0_href;
    logic [byte_width-1:0]     cam0_data;
    logic                      cam1_vsync;
    logic                      cam1_href;
    logic [byte_width-1:0]     cam1_data;
    logic                      wr_en;
    logic                      rd_en;
    logic [reg_addr_width-1:0] addr;
    logic [reg_data_width-1:0] wr_data;
    logic [reg_data_width-1:0] rd_data;
    logic                      rd_valid;
    logic                      cam0_tick;
    logic                      cam1_tick;

    logic [9:0]  stim [cam_count][max_cycles];  // {vsync, href, data} per clk cycle
    int          stim_len [cam_count];
    int          exp_pixels [cam_count];
    int          exp_lines [cam_count];
    logic [15:0] exp_csum [cam_count];
    int          exp_frames [cam_count];
    logic        cam_on [cam_count];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          test_base;
    int          ticks0;
    int          ticks1;

    capture_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            ticks0 <= 0;
            ticks1 <= 0;
        end else begin
            if (cam0_tick) ticks0 <= ticks0 + 1;  // counted where the tick is stable
            if (cam1_tick) ticks1 <= ticks1 + 1;
        end
    end

    // ********************
    // random numbers
    // ********************

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // ********************
    // host port
    // ********************

    task automatic write_reg(input logic [3:0] a, input logic [31:0] d);
        wr_en   = 1'b1;
        addr    = a;
        wr_data = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] a, output logic [31:0] d);
        int waited;
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en  = 1'b0;
        waited = 1;
        while (!rd_valid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        d = rd_data;
        checks++;
        if (!rd_valid) begin
            errors++;
            $display("Timeout: no rd_valid within %0d cycles of a read at address %0d",
                     wait_limit, a);
        end else if (waited != 1) begin
            errors++;
            $display("Error at time %0t: rd_valid came %0d cycles after rd_en", $time, waited);
        end
        @(negedge clk);
        if (rd_valid) begin
            errors++;
            $display("Error at time %0t: rd_valid stayed high a second cycle", $time);
        end
    endtask

    task automatic expect_reg(input logic [3:0] a, input logic [31:0] exp, input string what);
        logic [31:0] got;
        read_reg(a, got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic check_stats(input int cam);
        logic [3:0] base;
        base = (cam == 0) ? reg_pixels0 : reg_pixels1;
        expect_reg(base, exp_pixels[cam], $sformatf("camera %0d pixels", cam));
        expect_reg(base + 4'd1, exp_lines[cam], $sformatf("camera %0d lines", cam));
        expect_reg(base + 4'd2, {16'h0, exp_csum[cam]}, $sformatf("camera %0d checksum", cam));
        expect_reg(base + 4'd3, exp_frames[cam], $sformatf("camera %0d frames", cam));
    endtask

    // ********************
    // camera frames
    // ********************

    task automatic push_cycle(input int cam, input logic vs, input logic hr, input logic [7:0] d);
        stim[cam][stim_len[cam]] = {vs, hr, d};
        stim_len[cam]++;
    endtask

    // builds one frame and updates the model, which only counts while the camera is on
    task automatic build_frame(input int cam, input bit force_odd);
        int          nlines;
        int          nbytes;
        int          pix;
        int          lines;
        logic [15:0] csum;
        logic [7:0]  b;
        logic [7:0]  hi;
        stim_len[cam] = 0;
        pix   = 0;
        lines = 0;
        csum  = '0;
        push_cycle(cam, 1'b0, 1'b0, 8'h00);
        push_cycle(cam, 1'b0, 1'b0, 8'h00);
        nlines = 1 + int'(rand_bits(2));
        for (int l = 0; l < nlines; l++) begin
            nbytes = 1 + int'(rand_bits(3));
            if (force_odd) nbytes = nbytes | 1;
            for (int i = 0; i < nbytes; i++) begin
                b = 8'(rand_bits(8));
                push_cycle(cam, 1'b0, 1'b1, b);
                if (i % 2 == 0) begin
                    hi = b;  // first byte of the pair is the high half
                end else begin
                    pix++;
                    csum = csum ^ {hi, b};
                end
            end
            lines++;
            repeat (1 + int'(rand_bits(2))) push_cycle(cam, 1'b0, 1'b0, 8'h00);
        end
        push_cycle(cam, 1'b0, 1'b0, 8'h00);
        push_cycle(cam, 1'b0, 1'b0, 8'h00);
        repeat (3) push_cycle(cam, 1'b1, 1'b0, 8'h00);  // vsync closes the frame
        repeat (2) push_cycle(cam, 1'b0, 1'b0, 8'h00);
        if (cam_on[cam]) begin
            exp_pixels[cam] = pix;
            exp_lines[cam]  = lines;
            exp_csum[cam]   = csum;
            exp_frames[cam]++;
        end
    endtask

    task automatic play_frame(input int cam);
        for (int i = 0; i < stim_len[cam]; i++) begin
            if (cam == 0) {cam0_vsync, cam0_href, cam0_data} = stim[0][i];
            else {cam1_vsync, cam1_href, cam1_data} = stim[1][i];
            @(negedge clk);
        end
    endtask

    task automatic wait_ticks(input int cam, input int expected);
        int waited;
        int seen;
        waited = 0;
        seen   = (cam == 0) ? ticks0 : ticks1;
        while (seen < expected && waited < wait_limit) begin
            @(negedge clk);
            waited++;
            seen = (cam == 0) ? ticks0 : ticks1;
        end
        checks++;
        if (seen < expected) begin
            errors++;
            $display("Timeout: cam%0d_tick number %0d never arrived", cam, expected);
        end else if (seen != expected) begin
            errors++;
            $display("Error at time %0t: %0d ticks on camera %0d, expected %0d",
                     $time, seen, cam, expected);
        end
    endtask

    task automatic cam0_frame_and_ticks(input int expected);
        build_frame(0, 1'b0);
        play_frame(0);
        wait_ticks(0, expected);
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s done with %0d errors", num, name, errors - test_base);
        test_base = errors;
    endtask

    // ********************
    // test sequence
    // ********************

    initial begin
        rst_n      = 1'b0;
        {cam0_vsync, cam0_href, cam0_data} = '0;
        {cam1_vsync, cam1_href, cam1_data} = '0;
        wr_en      = 1'b0;
        rd_en      = 1'b0;
        addr       = '0;
        wr_data    = '0;
        lfsr       = 32'h4a64;
        errors     = 0;
        checks     = 0;
        test_base  = 0;
        for (int c = 0; c < cam_count; c++) begin
            exp_pixels[c] = 0;
            exp_lines[c]  = 0;
            exp_csum[c]   = '0;
            exp_frames[c] = 0;
            cam_on[c]     = 1'b1;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        expect_reg(reg_ctrl, 32'd3, "ctrl");
        expect_reg(reg_tick_div0, 32'd30, "tick_div0");
        expect_reg(reg_tick_div1, 32'd30, "tick_div1");
        check_stats(0);
        check_stats(1);
        expect_reg(4'd3, 32'd0, "unmapped address 3");
        expect_reg(4'd15, 32'd0, "unmapped address 15");
        finish_test(1, "reset values");

        repeat (4) begin
            build_frame(0, 1'b0);
            play_frame(0);
            check_stats(0);
        end
        check_stats(1);
        finish_test(2, "camera 0 frames");

        repeat (3) begin
            build_frame(0, 1'b0);
            build_frame(1, 1'b0);
            fork
                play_frame(0);
                play_frame(1);
            join
            check_stats(0);
            check_stats(1);
        end
        wait_ticks(1, 0);
        finish_test(3, "both cameras");

        repeat (3) begin
            build_frame(0, 1'b1);
            play_frame(0);
            check_stats(0);
        end
        finish_test(4, "odd byte lines");

        write_reg(reg_tick_div0, 32'd3);
        for (int f = 1; f <= 6; f++) cam0_frame_and_ticks(f / 3);
        write_reg(reg_tick_div0, 32'd0);  // zero divides like one
        for (int f = 1; f <= 2; f++) cam0_frame_and_ticks(2 + f);
        check_stats(0);
        finish_test(5, "frame tick");

        write_reg(reg_ctrl, 32'd1);
        write_reg(reg_tick_div1, 32'd1);  // every counted frame of camera 1 ticks
        cam_on[1] = 1'b0;
        expect_reg(reg_ctrl, 32'd1, "ctrl with camera 1 off");
        build_frame(1, 1'b0);
        play_frame(1);
        check_stats(1);
        wait_ticks(1, 0);
        write_reg(reg_ctrl, 32'd3);
        cam_on[1] = 1'b1;
        build_frame(1, 1'b0);
        play_frame(1);
        check_stats(1);
        wait_ticks(1, 1);
        finish_test(6, "camera enable");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
source/capture_pkg.sv
source/pixel_bus_if.sv
source/frame_stats_if.sv
source/rgb565_packer.sv
source/frame_monitor.sv
source/capture_regs.sv
source/capture_top.sv
tests/tb_capture_top.sv

// File: Makefile
# Verilator build and run for the dual camera capture front end

VERILATOR ?= verilator
TOP       ?= tb_capture_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the log
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "run FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
